//--- design/fp_slice_pkg.sv
// ----------------------------------------
// Shared definitions for the two-lane
// non-computational FP slice: formats,
// operation selectors, vector types and
// pipeline constants. Modules import it
// inside their bodies.
// ----------------------------------------

package fp_slice_pkg;

  // ----------------------------------------
  // Slice geometry
  // ----------------------------------------
  localparam int unsigned WIDTH         = 32;
  localparam int unsigned NUM_LANES     = 2;
  localparam int unsigned NUM_OPERANDS  = 2;
  localparam int unsigned NUM_PIPE_REGS = 2;
  localparam int unsigned FP16_WIDTH    = 16;  // Lane stride in the packed word

  // ----------------------------------------
  // Plain vector types
  // ----------------------------------------
  typedef logic [WIDTH-1:0] fp_word_t;
  typedef logic [31:0]      fp_lane_t;    // Lane 1 only fills the low half
  typedef logic [4:0]       fp_status_t;  // {NV, DZ, OF, UF, NX}
  typedef logic [NUM_LANES-1:0] lane_mask_t;
  typedef logic [3:0]       tag_t;
  typedef logic [1:0]       lane_aux_t;   // {vectorial, format}

  // Bit positions inside status and aux words
  localparam int unsigned STATUS_NV   = 4;
  localparam int unsigned AUX_VEC_BIT = 1;
  localparam int unsigned AUX_FMT_BIT = 0;

  // Canonical quiet NaNs
  localparam fp_lane_t    FP32_QNAN = 32'h7fc0_0000;
  localparam logic [15:0] FP16_QNAN = 16'h7e00;

  // ----------------------------------------
  // Enumerations
  // ----------------------------------------
  typedef enum logic {
    FMT_FP32 = 1'b0,
    FMT_FP16 = 1'b1
  } fp_fmt_e;

  typedef enum logic {
    OP_SGNJ   = 1'b0,
    OP_MINMAX = 1'b1
  } fp_op_e;

  // Rounding mode field, reused to pick the sub-operation
  // RNE: SGNJ / MIN, RTZ: SGNJN / MAX, RDN: SGNJX
  typedef enum logic [2:0] {
    RM_RNE = 3'b000,
    RM_RTZ = 3'b001,
    RM_RDN = 3'b010,
    RM_RUP = 3'b011,
    RM_RMM = 3'b100
  } fp_rm_e;

endpackage

//--- design/fp_noncomp_core.sv
// ----------------------------------------
// Combinational sign injection and min/max
// for one lane, FP32 or FP16. Operands are
// classified in the selected format; FP16
// results leave the upper half at zero.
// ----------------------------------------

`timescale 1ns/1ps

module fp_noncomp_core (
  input  fp_slice_pkg::fp_lane_t   op_a_i,
  input  fp_slice_pkg::fp_lane_t   op_b_i,
  input  fp_slice_pkg::fp_fmt_e    fmt_i,
  input  fp_slice_pkg::fp_op_e     op_i,
  input  fp_slice_pkg::fp_rm_e     rnd_mode_i,
  output fp_slice_pkg::fp_lane_t   result_o,
  output fp_slice_pkg::fp_status_t status_o
);

  import fp_slice_pkg::*;

  logic        sign_a, sign_b;
  logic [30:0] mag_a, mag_b;      // FP16 magnitudes are zero-extended
  logic        nan_a, nan_b;
  logic        snan_a, snan_b;
  logic [30:0] qnan_mag;          // Canonical NaN magnitude, sign is 0
  logic        a_lt_b;
  logic        res_sign;
  logic [30:0] res_mag;

  // ----------------------------------------
  // Operand classification
  // ----------------------------------------
  always_comb begin : classify
    if (fmt_i == FMT_FP16) begin
      sign_a   = op_a_i[15];
      sign_b   = op_b_i[15];
      mag_a    = {16'b0, op_a_i[14:0]};
      mag_b    = {16'b0, op_b_i[14:0]};
      nan_a    = (&op_a_i[14:10]) & (|op_a_i[9:0]);
      nan_b    = (&op_b_i[14:10]) & (|op_b_i[9:0]);
      snan_a   = nan_a & ~op_a_i[9];   // Quiet bit is mantissa MSB
      snan_b   = nan_b & ~op_b_i[9];
      qnan_mag = {16'b0, FP16_QNAN[14:0]};
    end else begin
      sign_a   = op_a_i[31];
      sign_b   = op_b_i[31];
      mag_a    = op_a_i[30:0];
      mag_b    = op_b_i[30:0];
      nan_a    = (&op_a_i[30:23]) & (|op_a_i[22:0]);
      nan_b    = (&op_b_i[30:23]) & (|op_b_i[22:0]);
      snan_a   = nan_a & ~op_a_i[22];
      snan_b   = nan_b & ~op_b_i[22];
      qnan_mag = FP32_QNAN[30:0];
    end
  end

  // Sign-magnitude ordering, -0 sorts below +0
  always_comb begin : order
    if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = (mag_a > mag_b);  // Both negative
    end else begin
      a_lt_b = (mag_a < mag_b);
    end
  end

  // ----------------------------------------
  // Operation select
  // ----------------------------------------
  always_comb begin : operation
    res_sign = sign_a;
    res_mag  = mag_a;
    status_o = '0;
    case (op_i)
      OP_SGNJ: begin
        // Magnitude of A, sign from the selector
        case (rnd_mode_i)
          RM_RNE: res_sign = sign_b;
          RM_RTZ: res_sign = ~sign_b;
          RM_RDN: res_sign = sign_a ^ sign_b;
          default: begin  // Unsupported selector
            res_sign            = 1'b0;
            res_mag             = qnan_mag;
            status_o[STATUS_NV] = 1'b1;
          end
        endcase
      end
      OP_MINMAX: begin
        status_o[STATUS_NV] = snan_a | snan_b;
        if (nan_a && nan_b) begin
          res_sign = 1'b0;
          res_mag  = qnan_mag;
        end else if (nan_a) begin
          res_sign = sign_b;  // Single NaN yields the other operand
          res_mag  = mag_b;
        end else if (nan_b) begin
          res_sign = sign_a;
          res_mag  = mag_a;
        end else if (rnd_mode_i == RM_RNE) begin
          res_sign = a_lt_b ? sign_a : sign_b;  // Minimum
          res_mag  = a_lt_b ? mag_a : mag_b;
        end else if (rnd_mode_i == RM_RTZ) begin
          res_sign = a_lt_b ? sign_b : sign_a;  // Maximum
          res_mag  = a_lt_b ? mag_b : mag_a;
        end else begin
          res_sign            = 1'b0;
          res_mag             = qnan_mag;
          status_o[STATUS_NV] = 1'b1;
        end
      end
    endcase
  end

  // Repack in the selected format
  assign result_o = (fmt_i == FMT_FP16) ? {16'b0, res_sign, res_mag[14:0]}
                                        : {res_sign, res_mag};

endmodule

//--- design/fp_lane_pipe.sv
// ----------------------------------------
// Elastic register pipeline for one lane.
// Each stage has its own valid bit; ready
// runs backwards combinationally. Carries
// result, status, tag, mask and aux data.
// ----------------------------------------

`timescale 1ns/1ps

module fp_lane_pipe (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  fp_slice_pkg::fp_lane_t   result_i,
  input  fp_slice_pkg::fp_status_t status_i,
  input  fp_slice_pkg::tag_t       tag_i,
  input  logic                     mask_i,
  input  fp_slice_pkg::lane_aux_t  aux_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  input  logic                     flush_i,
  output fp_slice_pkg::fp_lane_t   result_o,
  output fp_slice_pkg::fp_status_t status_o,
  output fp_slice_pkg::tag_t       tag_o,
  output logic                     mask_o,
  output fp_slice_pkg::lane_aux_t  aux_o,
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output logic                     busy_o
);

  import fp_slice_pkg::*;

  // Index i is the value after i register stages
  logic       valid_q  [NUM_PIPE_REGS+1];
  logic       ready    [NUM_PIPE_REGS+1];
  fp_lane_t   result_q [NUM_PIPE_REGS+1];
  fp_status_t status_q [NUM_PIPE_REGS+1];
  tag_t       tag_q    [NUM_PIPE_REGS+1];
  logic       mask_q   [NUM_PIPE_REGS+1];
  lane_aux_t  aux_q    [NUM_PIPE_REGS+1];

  // Stage 0 is the input port
  assign valid_q[0]  = in_valid_i;
  assign result_q[0] = result_i;
  assign status_q[0] = status_i;
  assign tag_q[0]    = tag_i;
  assign mask_q[0]   = mask_i;
  assign aux_q[0]    = aux_i;

  for (genvar i = 0; i < NUM_PIPE_REGS; i++) begin : gen_stages
    // Advance when the next stage moves on or holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i || flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (ready[i] && valid_q[i]) begin  // Load only real data
        result_q[i+1] <= result_q[i];
        status_q[i+1] <= status_q[i];
        tag_q[i+1]    <= tag_q[i];
        mask_q[i+1]   <= mask_q[i];
        aux_q[i+1]    <= aux_q[i];
      end
    end
  end

  assign ready[NUM_PIPE_REGS] = out_ready_i;  // Downstream drives the last stage
  assign in_ready_o           = ready[0];

  // ----------------------------------------
  // Output side
  // ----------------------------------------
  assign out_valid_o = valid_q[NUM_PIPE_REGS];
  assign result_o    = result_q[NUM_PIPE_REGS];
  assign status_o    = status_q[NUM_PIPE_REGS];
  assign tag_o       = tag_q[NUM_PIPE_REGS];
  assign mask_o      = mask_q[NUM_PIPE_REGS];
  assign aux_o       = aux_q[NUM_PIPE_REGS];

  always_comb begin : busy_detect
    busy_o = 1'b0;
    for (int unsigned i = 1; i <= NUM_PIPE_REGS; i++) begin
      busy_o |= valid_q[i];
    end
  end

endmodule

//--- design/fp_result_packer.sv
// ----------------------------------------
// Builds the 32-bit result word from the
// lane outputs. FP16 results are NaN-boxed
// when lane 1 is idle. Lane flags are
// merged under the SIMD mask.
// ----------------------------------------

`timescale 1ns/1ps

module fp_result_packer (
  input  fp_slice_pkg::fp_lane_t   lane0_result_i,
  input  fp_slice_pkg::fp_lane_t   lane1_result_i,
  input  fp_slice_pkg::fp_status_t lane0_status_i,
  input  fp_slice_pkg::fp_status_t lane1_status_i,
  input  fp_slice_pkg::lane_mask_t lane_mask_i,
  input  logic                     lane1_valid_i,
  input  fp_slice_pkg::lane_aux_t  aux_i,
  output fp_slice_pkg::fp_word_t   result_o,
  output fp_slice_pkg::fp_status_t status_o
);

  import fp_slice_pkg::*;

  fp_fmt_e     result_fmt;
  logic [15:0] upper_half;
  fp_status_t  lane0_flags, lane1_flags;

  // Aux word travels with lane 0
  assign result_fmt = fp_fmt_e'(aux_i[AUX_FMT_BIT]);

  // ----------------------------------------
  // Result assembly
  // ----------------------------------------
  assign upper_half = lane1_valid_i ? lane1_result_i[FP16_WIDTH-1:0] : 16'hffff;

  always_comb begin : pack
    if (result_fmt == FMT_FP16) begin
      result_o = {upper_half, lane0_result_i[FP16_WIDTH-1:0]};
    end else begin
      result_o = lane0_result_i;
    end
  end

  // ----------------------------------------
  // Status collapse
  // ----------------------------------------
  assign lane0_flags = lane0_status_i & {5{lane_mask_i[0]}};
  assign lane1_flags = lane1_valid_i ? (lane1_status_i & {5{lane_mask_i[1]}}) : '0;
  assign status_o    = lane0_flags | lane1_flags;

endmodule

//--- design/fp_noncomp_slice.sv
// ----------------------------------------
// Two-lane SIMD slice for sign injection
// and min/max. FP32 runs on lane 0, FP16
// vectors use both lanes. Valid/ready in,
// valid/ready out, with flush and busy.
// ----------------------------------------

`timescale 1ns/1ps

module fp_noncomp_slice (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  fp_slice_pkg::fp_word_t   operand_a_i,
  input  fp_slice_pkg::fp_word_t   operand_b_i,
  input  fp_slice_pkg::fp_op_e     op_i,
  input  fp_slice_pkg::fp_rm_e     rnd_mode_i,
  input  fp_slice_pkg::fp_fmt_e    fmt_i,
  input  logic                     vectorial_op_i,
  input  fp_slice_pkg::lane_mask_t simd_mask_i,
  input  fp_slice_pkg::tag_t       tag_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  input  logic                     flush_i,
  output fp_slice_pkg::fp_word_t   result_o,
  output fp_slice_pkg::fp_status_t status_o,
  output fp_slice_pkg::tag_t       tag_o,
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output logic                     busy_o
);

  import fp_slice_pkg::*;

  fp_word_t   operands [NUM_OPERANDS];
  lane_aux_t  aux_data;
  logic       lane1_active;      // Input op needs the upper lane
  logic       result_vec_fp16;   // Output op occupies the upper lane

  logic       lane_in_ready  [NUM_LANES];
  logic       lane_out_valid [NUM_LANES];
  logic       lane_busy      [NUM_LANES];
  fp_lane_t   lane_result    [NUM_LANES];
  fp_status_t lane_status    [NUM_LANES];
  tag_t       lane_tag       [NUM_LANES];
  lane_aux_t  lane_aux       [NUM_LANES];
  lane_mask_t lane_masks;

  // ----------------------------------------
  // Input side
  // ----------------------------------------
  assign operands[0]  = operand_a_i;
  assign operands[1]  = operand_b_i;
  assign lane1_active = vectorial_op_i & (fmt_i == FMT_FP16);
  assign aux_data     = {vectorial_op_i, fmt_i};

  // Lane 1 holds a subset of lane 0's ops and has room whenever lane 0 does
  assign in_ready_o = lane_in_ready[0];

  // ----------------------------------------
  // Lanes
  // ----------------------------------------
  for (genvar lane = 0; lane < NUM_LANES; lane++) begin : gen_lanes
    fp_lane_t   local_ops [NUM_OPERANDS];
    fp_lane_t   core_result;
    fp_status_t core_status;
    logic       in_valid, out_ready;

    // Upper bits above the lane are ignored by the core
    always_comb begin : slice_operands
      for (int unsigned i = 0; i < NUM_OPERANDS; i++) begin
        local_ops[i] = operands[i] >> (lane * FP16_WIDTH);
      end
    end

    assign in_valid  = in_valid_i & ((lane == 0) | lane1_active);
    assign out_ready = out_ready_i & ((lane == 0) | result_vec_fp16);

    fp_noncomp_core i_core (
      .op_a_i     ( local_ops[0] ),
      .op_b_i     ( local_ops[1] ),
      .fmt_i      ( fmt_i        ),
      .op_i       ( op_i         ),
      .rnd_mode_i ( rnd_mode_i   ),
      .result_o   ( core_result  ),
      .status_o   ( core_status  )
    );

    fp_lane_pipe i_pipe (
      .clk_i       ( clk_i                ),
      .rst_n_i     ( rst_n_i              ),
      .result_i    ( core_result          ),
      .status_i    ( core_status          ),
      .tag_i       ( tag_i                ),
      .mask_i      ( simd_mask_i[lane]    ),
      .aux_i       ( aux_data             ),
      .in_valid_i  ( in_valid             ),
      .in_ready_o  ( lane_in_ready[lane]  ),
      .flush_i     ( flush_i              ),
      .result_o    ( lane_result[lane]    ),
      .status_o    ( lane_status[lane]    ),
      .tag_o       ( lane_tag[lane]       ),
      .mask_o      ( lane_masks[lane]     ),
      .aux_o       ( lane_aux[lane]       ),
      .out_valid_o ( lane_out_valid[lane] ),
      .out_ready_i ( out_ready            ),
      .busy_o      ( lane_busy[lane]      )
    );
  end

  // ----------------------------------------
  // Output side
  // ----------------------------------------
  assign result_vec_fp16 = lane_aux[0][AUX_VEC_BIT] &
                           (fp_fmt_e'(lane_aux[0][AUX_FMT_BIT]) == FMT_FP16);

  fp_result_packer i_packer (
    .lane0_result_i ( lane_result[0]                       ),
    .lane1_result_i ( lane_result[1]                       ),
    .lane0_status_i ( lane_status[0]                       ),
    .lane1_status_i ( lane_status[1]                       ),
    .lane_mask_i    ( lane_masks                           ),
    .lane1_valid_i  ( lane_out_valid[1] & result_vec_fp16  ),
    .aux_i          ( lane_aux[0]                          ),
    .result_o       ( result_o                             ),
    .status_o       ( status_o                             )
  );

  assign tag_o       = lane_tag[0];        // Lane 0 owns the tag
  assign out_valid_o = lane_out_valid[0];
  assign busy_o      = lane_busy[0] | lane_busy[1];

endmodule

//--- testbench/fp_noncomp_slice_properties.sv
// ----------------------------------------
// Handshake checks on the slice outputs.
// Bound to the top level by the testbench;
// failures raise $error.
// ----------------------------------------

`timescale 1ns/1ps

module fp_noncomp_slice_properties (
  input logic                     clk_i,
  input logic                     rst_n_i,
  input logic                     flush_i,
  input logic                     out_valid_i,
  input logic                     out_ready_i,
  input logic                     busy_i,
  input fp_slice_pkg::fp_word_t   result_i,
  input fp_slice_pkg::fp_status_t status_i,
  input fp_slice_pkg::tag_t       tag_i
);

  int unsigned violations = 0;

  // A stalled result holds until it is taken or flushed
  stall_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i && !out_ready_i && !flush_i |=>
      out_valid_i && $stable(result_i) && $stable(status_i) && $stable(tag_i))
    else begin
      violations++;
      $error("Output data changed while stalled");
    end

  reset_idle: assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_i)
    else begin
      violations++;
      $error("out_valid high in the cycle after reset");
    end

  valid_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i |-> busy_i)  // Output data sits in a stage
    else begin
      violations++;
      $error("out_valid high while busy low");
    end

endmodule

//--- testbench/tb_fp_noncomp_slice.sv
// ----------------------------------------
// Testbench for the two-lane FP slice.
// Applies the stimulus table without and
// with output stalls, then a flush phase;
// results are checked in arrival order.
// ----------------------------------------

`timescale 1ns/1ps

module tb_fp_noncomp_slice;

  import fp_slice_pkg::*;

  typedef struct packed {
    fp_word_t   a;
    fp_word_t   b;
    fp_op_e     op;
    fp_rm_e     rm;
    fp_fmt_e    fmt;
    logic       vec;
    lane_mask_t mask;
    fp_word_t   exp_result;
    fp_status_t exp_status;
  } test_vec_t;

  localparam int READY_OFF    = 0;
  localparam int READY_ON     = 1;
  localparam int READY_RANDOM = 2;

  logic       clk_i = 1'b0;
  logic       rst_n_i;
  fp_word_t   operand_a_i, operand_b_i;
  fp_op_e     op_i;
  fp_rm_e     rnd_mode_i;
  fp_fmt_e    fmt_i;
  logic       vectorial_op_i;
  lane_mask_t simd_mask_i;
  tag_t       tag_i;
  logic       in_valid_i, in_ready_o, flush_i;
  fp_word_t   result_o;
  fp_status_t status_o;
  tag_t       tag_o;
  logic       out_valid_o, busy_o;
  logic       out_ready_i = 1'b0;

  test_vec_t    table_q [$];
  int unsigned  exp_idx_q [$];      // Table index per accepted op
  tag_t         exp_tag_q [$];
  int unsigned  accept_cycle [16];  // Indexed by tag
  logic [255:0] ready_pattern;
  int           ready_mode    = READY_OFF;
  logic         check_latency = 1'b0;
  int unsigned  cycle_count   = 0;
  int unsigned  timeout_limit = 200;
  int unsigned  passed = 0;
  int unsigned  failed = 0;
  int unsigned  errors = 0;
  tag_t         next_tag = '0;

  fp_noncomp_slice i_dut (.*);

  bind fp_noncomp_slice fp_noncomp_slice_properties i_props (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .flush_i     ( flush_i     ),
    .out_valid_i ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .busy_i      ( busy_o      ),
    .result_i    ( result_o    ),
    .status_i    ( status_o    ),
    .tag_i       ( tag_o       )
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("Timeout after %0d cycles, %0d results outstanding",
               cycle_count, exp_idx_q.size());
      $display(">>> FAIL");
      $finish;
    end
  end

  // Output ready follows the phase mode
  always @(negedge clk_i) begin
    case (ready_mode)
      READY_ON:     out_ready_i = 1'b1;
      READY_RANDOM: out_ready_i = ready_pattern[cycle_count % 256];
      default:      out_ready_i = 1'b0;
    endcase
  end

  always @(posedge clk_i) begin
    if (rst_n_i && out_valid_o && out_ready_i) begin
      check_result();
    end
  end

  // ----------------------------------------
  // Tasks
  // ----------------------------------------
  task automatic add_case(input fp_word_t a, input fp_word_t b, input fp_op_e op,
                          input fp_rm_e rm, input fp_fmt_e fmt, input logic vec,
                          input lane_mask_t mask, input fp_word_t res,
                          input fp_status_t st);
    table_q.push_back('{a, b, op, rm, fmt, vec, mask, res, st});
  endtask

  task automatic check_result();
    int unsigned idx;
    tag_t        tag;
    int unsigned errs_before;
    if (exp_idx_q.size() == 0) begin
      $display("Unexpected result with tag %h at %0t, no operation outstanding",
               tag_o, $time);
      errors++;
      return;
    end
    idx         = exp_idx_q.pop_front();
    tag         = exp_tag_q.pop_front();
    errs_before = errors;
    assert (tag_o == tag) else begin
      $display("MISMATCH at %0t: test %0d tag %h, expected %h", $time, idx, tag_o, tag);
      errors++;
    end
    assert (result_o == table_q[idx].exp_result) else begin
      $display("MISMATCH at %0t: test %0d result %h, expected %h",
               $time, idx, result_o, table_q[idx].exp_result);
      errors++;
    end
    assert (status_o == table_q[idx].exp_status) else begin
      $display("MISMATCH at %0t: test %0d status %b, expected %b",
               $time, idx, status_o, table_q[idx].exp_status);
      errors++;
    end
    if (check_latency) begin
      assert (cycle_count - accept_cycle[tag] == NUM_PIPE_REGS) else begin
        $display("Test %0d took %0d cycles from acceptance to result",
                 idx, cycle_count - accept_cycle[tag]);
        errors++;
      end
    end
    if (errors == errs_before) begin
      passed++;
      $display("test %2d tag %h ok", idx, tag);
    end else begin
      failed++;
      $display("test %2d tag %h FAILED", idx, tag);
    end
  endtask

  task automatic issue(input int unsigned idx);
    @(negedge clk_i);
    operand_a_i    = table_q[idx].a;
    operand_b_i    = table_q[idx].b;
    op_i           = table_q[idx].op;
    rnd_mode_i     = table_q[idx].rm;
    fmt_i          = table_q[idx].fmt;
    vectorial_op_i = table_q[idx].vec;
    simd_mask_i    = table_q[idx].mask;
    tag_i          = next_tag;
    in_valid_i     = 1'b1;
    do @(posedge clk_i); while (!in_ready_o);
    accept_cycle[next_tag] = cycle_count;
    exp_idx_q.push_back(idx);
    exp_tag_q.push_back(next_tag);
    next_tag++;
  endtask

  task automatic release_and_drain();
    @(negedge clk_i);
    in_valid_i = 1'b0;
    while (exp_idx_q.size() != 0) begin
      @(posedge clk_i);
    end
  endtask

  task automatic set_ready_mode(input int mode);
    @(posedge clk_i);
    ready_mode = mode;
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin : run
    int unsigned i;
    void'($urandom(32'hc053_71e9));
    rst_n_i        = 1'b0;
    operand_a_i    = '0;
    operand_b_i    = '0;
    op_i           = OP_SGNJ;
    rnd_mode_i     = RM_RNE;
    fmt_i          = FMT_FP32;
    vectorial_op_i = 1'b0;
    simd_mask_i    = '0;
    tag_i          = '0;
    in_valid_i     = 1'b0;
    flush_i        = 1'b0;

    // a, b, op, rnd_mode, fmt, vectorial, mask, expected result, expected status
    add_case('h3f800000, 'h40000000, OP_MINMAX, RM_RNE, FMT_FP32, 0, 2'b11, 'h3f800000, 'h00);
    add_case('h3f800000, 'h40000000, OP_MINMAX, RM_RTZ, FMT_FP32, 0, 2'b11, 'h40000000, 'h00);
    add_case('hbf800000, 'h3f800000, OP_MINMAX, RM_RNE, FMT_FP32, 0, 2'b11, 'hbf800000, 'h00);
    add_case('hc0000000, 'hbf800000, OP_MINMAX, RM_RNE, FMT_FP32, 0, 2'b11, 'hc0000000, 'h00);
    add_case('h00000000, 'h80000000, OP_MINMAX, RM_RNE, FMT_FP32, 0, 2'b11, 'h80000000, 'h00);
    add_case('h7fc00000, 'h40000000, OP_MINMAX, RM_RNE, FMT_FP32, 0, 2'b11, 'h40000000, 'h00);
    add_case('h3f800000, 'h7f800001, OP_MINMAX, RM_RTZ, FMT_FP32, 0, 2'b11, 'h3f800000, 'h10);
    add_case('h7fc00000, 'h7f800001, OP_MINMAX, RM_RNE, FMT_FP32, 0, 2'b11, 'h7fc00000, 'h10);
    add_case('hffc00000, 'h7fc00000, OP_MINMAX, RM_RTZ, FMT_FP32, 0, 2'b11, 'h7fc00000, 'h00);
    add_case('h3f800000, 'h80000000, OP_SGNJ,   RM_RNE, FMT_FP32, 0, 2'b11, 'hbf800000, 'h00);
    add_case('h3f800000, 'h80000000, OP_SGNJ,   RM_RTZ, FMT_FP32, 0, 2'b11, 'h3f800000, 'h00);
    add_case('hbf800000, 'h80000000, OP_SGNJ,   RM_RDN, FMT_FP32, 0, 2'b11, 'h3f800000, 'h00);
    add_case('h7f800001, 'h80000000, OP_SGNJ,   RM_RNE, FMT_FP32, 0, 2'b11, 'hff800001, 'h00);
    add_case('hdead3c00, 'h00008000, OP_SGNJ,   RM_RNE, FMT_FP16, 0, 2'b11, 'hffffbc00, 'h00);
    add_case('h0000bc00, 'h00008000, OP_SGNJ,   RM_RTZ, FMT_FP16, 0, 2'b11, 'hffff3c00, 'h00);
    add_case('h0000bc00, 'h00004000, OP_SGNJ,   RM_RDN, FMT_FP16, 0, 2'b11, 'hffffbc00, 'h00);
    add_case('h7c013c00, 'h7c014000, OP_MINMAX, RM_RNE, FMT_FP16, 0, 2'b11, 'hffff3c00, 'h00);
    add_case('h40003c00, 'h3c00c000, OP_MINMAX, RM_RNE, FMT_FP16, 1, 2'b11, 'h3c00c000, 'h00);
    add_case('h80007e00, 'h00003c00, OP_MINMAX, RM_RTZ, FMT_FP16, 1, 2'b11, 'h00003c00, 'h00);
    add_case('h3c00c000, 'h80008000, OP_SGNJ,   RM_RDN, FMT_FP16, 1, 2'b11, 'hbc004000, 'h00);
    add_case('h7e003c00, 'h7c014000, OP_MINMAX, RM_RNE, FMT_FP16, 1, 2'b11, 'h7e003c00, 'h10);
    add_case('h7e003c00, 'h7c014000, OP_MINMAX, RM_RNE, FMT_FP16, 1, 2'b01, 'h7e003c00, 'h00);
    add_case('h7c013c00, 'h40003800, OP_MINMAX, RM_RNE, FMT_FP16, 1, 2'b10, 'h40003800, 'h10);
    add_case('h3c007c01, 'h40003c00, OP_MINMAX, RM_RNE, FMT_FP16, 1, 2'b10, 'h3c003c00, 'h00);
    add_case('h7f800001, 'hbf800000, OP_MINMAX, RM_RNE, FMT_FP32, 0, 2'b00, 'hbf800000, 'h00);

    timeout_limit = table_q.size() * 20 + 200;
    for (i = 0; i < 256; i++) begin
      ready_pattern[i] = $urandom % 2;
    end

    repeat (5) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    assert (in_ready_o && !out_valid_o && !busy_o) else begin
      $display("Slice not idle after reset at %0t", $time);
      errors++;
    end

    // No stalls, every result two cycles after acceptance
    check_latency = 1'b1;
    set_ready_mode(READY_ON);
    for (i = 0; i < table_q.size(); i++) begin
      issue(i);
    end
    release_and_drain();

    // Same table under random back-pressure
    check_latency = 1'b0;
    set_ready_mode(READY_RANDOM);
    for (i = 0; i < table_q.size(); i++) begin
      issue(i);
    end
    release_and_drain();

    // Flush two vector ops held in the stages
    set_ready_mode(READY_OFF);
    issue(17);
    issue(19);
    @(negedge clk_i);
    in_valid_i = 1'b0;
    flush_i    = 1'b1;
    @(posedge clk_i);
    exp_idx_q.delete();
    exp_tag_q.delete();
    @(negedge clk_i);
    flush_i = 1'b0;
    assert (!busy_o && !out_valid_o) else begin
      $display("Pipeline still busy after flush at %0t", $time);
      errors++;
    end
    set_ready_mode(READY_ON);
    repeat (4) @(posedge clk_i);
    check_latency = 1'b1;
    issue(20);
    release_and_drain();
    repeat (4) @(posedge clk_i);

    $display("Results: %0d passed, %0d failed, %0d errors, %0d assertion failures",
             passed, failed, errors, i_dut.i_props.violations);
    if (errors == 0 && i_dut.i_props.violations == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- tb.f
design/fp_slice_pkg.sv
design/fp_noncomp_core.sv
design/fp_lane_pipe.sv
design/fp_result_packer.sv
design/fp_noncomp_slice.sv
testbench/fp_noncomp_slice_properties.sv
testbench/tb_fp_noncomp_slice.sv
